/* vlog.f */
+incdir+.
conv_data_pkg.sv
conv_geom_pkg.sv
conv_window_if.sv
conv_window_gen.sv
conv_mac_tree.sv
conv_requant.sv
conv_top.sv
tb_conv_top.sv

/* Makefile */
# Verilator flow for the 3x3 convolution engine

TOP := tb_conv_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)
	verilator --lint-only --timing -f vlog.f --top-module conv_top

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q "TESTS FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" sim.log || (echo "No pass message in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* tb_conv_top.sv */
`timescale 1ns/1ps
`include "conv_settings.svh"

module tb_conv_top;

  import conv_data_pkg::*;
  import conv_geom_pkg::*;

  localparam int     WIDTH          = `CONV_IMAGE_WIDTH;
  localparam int     PIX_BITS       = `CONV_PIXEL_WIDTH;
  localparam int     FRAC           = `CONV_FRAC_BITS;
  localparam int     ROWS           = 6;
  localparam int     MAX_GAP        = 3;
  localparam int     PART_COLS      = 5;
  localparam int     FULL_WINDOWS   = (WIDTH - 2) * (ROWS - 2);
  // Five full frames plus one frame cut short in row 3
  localparam int     TOTAL_PIXELS   = 5 * ROWS * WIDTH + 3 * WIDTH + PART_COLS;
  localparam int     TIMEOUT_CYCLES = TOTAL_PIXELS * (MAX_GAP + 1) + 500;
  localparam longint PIX_MAX        = (longint'(1) <<< (PIX_BITS - 1)) - 1;
  localparam longint PIX_MIN        = -PIX_MAX - 1;

  // Frame contents
  localparam int PIX_SMALL   = 0;
  localparam int PIX_MID     = 1;
  localparam int PIX_EXTREME = 2;

  // Kernel contents
  localparam int KERN_IDENTITY = 0;
  localparam int KERN_SMALL    = 1;
  localparam int KERN_MAX      = 2;

  logic    clk = 1'b0;
  logic    reset;
  logic    weight_wr;
  tap_t    weight_addr;
  weight_t weight_data;
  logic    frame_start;
  logic    pixel_valid;
  pixel_t  pixel_data;
  logic    result_valid;
  pixel_t  result_data;

  pixel_t      frame_pix [ROWS][WIDTH];
  weight_t     kernel    [9];
  pixel_t      exp_data_q[$];
  int          exp_cycle_q[$];
  pixel_t      exp_data;
  int          exp_cycle;
  int          result_count = 0;
  int          cycle = 0;
  logic [31:0] rng_state = 32'hdae4_5ade;

  conv_top UUT (
    .clk          (clk),
    .reset        (reset),
    .weight_wr    (weight_wr),
    .weight_addr  (weight_addr),
    .weight_data  (weight_data),
    .frame_start  (frame_start),
    .pixel_valid  (pixel_valid),
    .pixel_data   (pixel_data),
    .result_valid (result_valid),
    .result_data  (result_data)
  );

  initial begin
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Window ending at row r, column c: sum of taps times weights, shift, clamp
  function automatic pixel_t ref_window(input int r, input int c);
    longint sum;
    longint scaled;
    sum = 0;
    for (int i = 0; i < 3; i++) begin
      for (int j = 0; j < 3; j++) begin
        sum += longint'(frame_pix[r-2+i][c-2+j]) * longint'(kernel[i*3+j]);
      end
    end
    scaled = sum >>> FRAC;
    if (scaled > PIX_MAX) begin
      scaled = PIX_MAX;
    end else if (scaled < PIX_MIN) begin
      scaled = PIX_MIN;
    end
    return pixel_t'(scaled);
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      pixel_valid = 1'b0;
      frame_start = 1'b0;
    end
  endtask

  task automatic load_kernel(input int mode);
    logic [31:0] rnd;
    weight_t     value;
    for (int i = 0; i < 9; i++) begin
      rnd = next_random();
      case (mode)
        KERN_IDENTITY: value = (i == 4) ? weight_t'(1 << FRAC) : '0;
        KERN_SMALL:    value = weight_t'($signed(rnd[5:0]));
        default:       value = weight_t'(PIX_MAX);
      endcase
      @(posedge clk);
      #1;
      weight_wr   = 1'b1;
      weight_addr = tap_t'(i);
      weight_data = value;
      kernel[i]   = value;
    end
    @(posedge clk);
    #1;
    weight_wr = 1'b0;
  endtask

  task automatic fill_frame(input int mode);
    logic [31:0] rnd;
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < WIDTH; c++) begin
        rnd = next_random();
        case (mode)
          PIX_SMALL: frame_pix[r][c] = pixel_t'($signed(rnd[7:0]));
          PIX_MID:   frame_pix[r][c] = pixel_t'($signed(rnd[9:0]));
          // Top rows at the maximum, bottom rows at the minimum
          default:   frame_pix[r][c] = (r < 3) ? pixel_t'(PIX_MAX) : pixel_t'(PIX_MIN);
        endcase
      end
    end
  endtask

  // Expected result is due 7 cycles after the window's last pixel
  task automatic send_pixel(input int r, input int c, input logic first);
    @(posedge clk);
    #1;
    frame_start = first;
    pixel_valid = 1'b1;
    pixel_data  = frame_pix[r][c];
    if (r >= 2 && c >= 2) begin
      exp_data_q.push_back(ref_window(r, c));
      exp_cycle_q.push_back(cycle + 7);
    end
  endtask

  task automatic send_frame(input int count, input int max_gap);
    logic [31:0] rnd;
    for (int k = 0; k < count; k++) begin
      if (max_gap > 0) begin
        rnd = next_random();
        idle_cycles(int'(rnd % (max_gap + 1)));
      end
      send_pixel(k / WIDTH, k % WIDTH, k == 0);
    end
  endtask

  // Last result is due 7 cycles after the final pixel
  task automatic wait_drain();
    idle_cycles(10);
  endtask

  task automatic check_count(input int first_count, input int expected);
    assert (result_count - first_count == expected)
      else report_failure($sformatf("%0d results arrived where %0d windows were expected",
                                    result_count - first_count, expected));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Cycle counter, timeout and comparison
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycle <= cycle + 1;
    assert (cycle < TIMEOUT_CYCLES)
      else report_failure($sformatf("Timeout, run still busy after %0d cycles", cycle));
  end

  // Outputs settle after the rising edge, so look at them on the falling one
  always @(negedge clk) begin
    if (!reset && result_valid === 1'b1) begin
      assert (exp_data_q.size() != 0)
        else report_failure("A result arrived with no window pending");
      if (exp_data_q.size() != 0) begin
        exp_data  = exp_data_q.pop_front();
        exp_cycle = exp_cycle_q.pop_front();
        result_count++;
        assert (result_data === exp_data)
          else report_failure($sformatf("FAIL result_data expected 0x%h got 0x%h",
                                        exp_data, result_data));
        assert (cycle == exp_cycle)
          else report_failure($sformatf("A result arrived in cycle %0d instead of cycle %0d",
                                        cycle, exp_cycle));
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int mark;
    reset       = 1'b1;
    weight_wr   = 1'b0;
    weight_addr = '0;
    weight_data = '0;
    frame_start = 1'b0;
    pixel_valid = 1'b0;
    pixel_data  = '0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    // Identity kernel passes the centre pixel through
    load_kernel(KERN_IDENTITY);
    fill_frame(PIX_SMALL);
    mark = result_count;
    send_frame(ROWS * WIDTH, 0);
    wait_drain();
    check_count(mark, FULL_WINDOWS);

    // Two random frames back to back
    load_kernel(KERN_SMALL);
    mark = result_count;
    fill_frame(PIX_MID);
    send_frame(ROWS * WIDTH, 0);
    fill_frame(PIX_MID);
    send_frame(ROWS * WIDTH, 0);
    wait_drain();
    check_count(mark, 2 * FULL_WINDOWS);

    // Saturation at both ends of the pixel range
    load_kernel(KERN_MAX);
    fill_frame(PIX_EXTREME);
    mark = result_count;
    send_frame(ROWS * WIDTH, 0);
    wait_drain();
    check_count(mark, FULL_WINDOWS);

    // Idle gaps, and a frame cut short by a new frame_start
    load_kernel(KERN_SMALL);
    fill_frame(PIX_MID);
    mark = result_count;
    send_frame(3 * WIDTH + PART_COLS, MAX_GAP);
    fill_frame(PIX_MID);
    send_frame(ROWS * WIDTH, MAX_GAP);
    wait_drain();
    check_count(mark, (WIDTH - 2) + (PART_COLS - 2) + FULL_WINDOWS);

    if (exp_data_q.size() == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      report_failure($sformatf("%0d expected results never arrived", exp_data_q.size()));
    end
  end

endmodule

/* conv_top.sv */
`timescale 1ns/1ps

module conv_top (
  input  logic                   clk,
  input  logic                   reset,

  // Weight load
  input  logic                   weight_wr,
  input  conv_geom_pkg::tap_t    weight_addr,
  input  conv_data_pkg::weight_t weight_data,

  // Pixel stream, raster order
  input  logic                   frame_start,
  input  logic                   pixel_valid,
  input  conv_data_pkg::pixel_t  pixel_data,

  // One result per fully covered window
  output logic                   result_valid,
  output conv_data_pkg::pixel_t  result_data
);

  import conv_data_pkg::*;

  logic acc_valid;
  acc_t acc;

  conv_window_if win_bus ();

  ////////////////////////////////////////////////////////////////////////////
  // Decode, execute, result
  ////////////////////////////////////////////////////////////////////////////

  conv_window_gen u_window_gen (
    .clk         (clk),
    .reset       (reset),
    .frame_start (frame_start),
    .pixel_valid (pixel_valid),
    .pixel_data  (pixel_data),
    .win         (win_bus.producer)
  );

  conv_mac_tree u_mac_tree (
    .clk         (clk),
    .reset       (reset),
    .weight_wr   (weight_wr),
    .weight_addr (weight_addr),
    .weight_data (weight_data),
    .win         (win_bus.consumer),
    .acc_valid   (acc_valid),
    .acc         (acc)
  );

  // Shift and saturate back to pixel width
  conv_requant u_requant (
    .clk          (clk),
    .reset        (reset),
    .acc_valid    (acc_valid),
    .acc          (acc),
    .result_valid (result_valid),
    .result_data  (result_data)
  );

endmodule

/* conv_requant.sv */
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_requant (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  acc_valid,
  input  conv_data_pkg::acc_t   acc,
  output logic                  result_valid,
  output conv_data_pkg::pixel_t result_data
);

  import conv_data_pkg::*;

  // Signed pixel range expressed at accumulator width
  localparam acc_t PIX_MAX = (acc_t'(1) <<< (`CONV_PIXEL_WIDTH - 1)) - acc_t'(1);
  localparam acc_t PIX_MIN = -PIX_MAX - acc_t'(1);

  acc_t   shifted;
  pixel_t clamped;

  // Arithmetic shift rounds toward minus infinity
  assign shifted = acc >>> `CONV_FRAC_BITS;

  always_comb begin
    if (shifted > PIX_MAX) begin
      clamped = pixel_t'(PIX_MAX);
    end else if (shifted < PIX_MIN) begin
      clamped = pixel_t'(PIX_MIN);
    end else begin
      clamped = pixel_t'(shifted);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= acc_valid;
    end
    if (acc_valid) begin
      result_data <= clamped;
    end
  end

  result_follows_acc: assert property (
    @(posedge clk) disable iff (reset) result_valid == $past(acc_valid)
  );

endmodule

/* conv_mac_tree.sv */
`timescale 1ns/1ps

module conv_mac_tree (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   weight_wr,
  input  conv_geom_pkg::tap_t    weight_addr,
  input  conv_data_pkg::weight_t weight_data,
  conv_window_if.consumer        win,
  output logic                   acc_valid,
  output conv_data_pkg::acc_t    acc
);

  import conv_data_pkg::*;
  import conv_geom_pkg::*;

  weight_t    weights [NUM_TAPS];
  pixel_t     taps    [NUM_TAPS];
  product_t   mult    [NUM_TAPS];
  acc_t       prod    [NUM_TAPS];
  acc_t       lvl1    [5];
  acc_t       lvl2    [3];
  acc_t       lvl3    [2];

  // Bit 0 marks the product stage, bit 3 the last partial sums
  logic [3:0] valid_pipe;

  ////////////////////////////////////////////////////////////////////////////
  // Weight bank
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_TAPS; i++) begin
        weights[i] <= '0;
      end
    end else if (weight_wr && (weight_addr < tap_t'(NUM_TAPS))) begin
      weights[weight_addr] <= weight_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Multipliers
  ////////////////////////////////////////////////////////////////////////////

  // Tap index is row * 3 + column
  always_comb begin
    for (int c = 0; c < 3; c++) begin
      taps[c]     = win.row_top[c];
      taps[3 + c] = win.row_mid[c];
      taps[6 + c] = win.row_bot[c];
    end
    for (int i = 0; i < NUM_TAPS; i++) begin
      mult[i] = product_t'(taps[i]) * product_t'(weights[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (win.win_valid) begin
      for (int i = 0; i < NUM_TAPS; i++) begin
        prod[i] <= acc_t'(mult[i]);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Adder tree 9 -> 5 -> 3 -> 2 -> 1
  ////////////////////////////////////////////////////////////////////////////

  // The odd operand of each level is carried through a register
  always_ff @(posedge clk) begin
    if (valid_pipe[0]) begin
      for (int i = 0; i < 4; i++) begin
        lvl1[i] <= prod[2*i] + prod[2*i+1];
      end
      lvl1[4] <= prod[8];
    end
    if (valid_pipe[1]) begin
      lvl2[0] <= lvl1[0] + lvl1[1];
      lvl2[1] <= lvl1[2] + lvl1[3];
      lvl2[2] <= lvl1[4];
    end
    if (valid_pipe[2]) begin
      lvl3[0] <= lvl2[0] + lvl2[1];
      lvl3[1] <= lvl2[2];
    end
    if (valid_pipe[3]) begin
      acc <= lvl3[0] + lvl3[1];
    end
  end

  // Valid travels with the data, five stages in all
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_pipe <= '0;
      acc_valid  <= 1'b0;
    end else begin
      valid_pipe <= {valid_pipe[2:0], win.win_valid};
      acc_valid  <= valid_pipe[3];
    end
  end

  weight_addr_legal: assert property (
    @(posedge clk) disable iff (reset) weight_wr |-> weight_addr < tap_t'(NUM_TAPS)
  );

  acc_valid_known: assert property (
    @(posedge clk) disable iff (reset) !$isunknown(acc_valid)
  );

endmodule

/* conv_window_gen.sv */
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_window_gen (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  frame_start,
  input  logic                  pixel_valid,
  input  conv_data_pkg::pixel_t pixel_data,
  conv_window_if.producer       win
);

  import conv_data_pkg::*;
  import conv_geom_pkg::*;

  localparam int   ADDR_BITS = $clog2(`CONV_IMAGE_WIDTH);
  localparam col_t LAST_COL  = col_t'(`CONV_IMAGE_WIDTH - 1);
  localparam col_t FIRST_WIN = col_t'(2);

  // Line buffers, line_prev holds row r-1 and line_old holds row r-2
  pixel_t line_prev [`CONV_IMAGE_WIDTH];
  pixel_t line_old  [`CONV_IMAGE_WIDTH];

  col_t                 col;
  col_t                 col_eff;
  fill_state_t          state;
  fill_state_t          state_eff;
  logic [ADDR_BITS-1:0] rd_addr;
  pixel_t               tap_prev;
  pixel_t               tap_old;

  ////////////////////////////////////////////////////////////////////////////
  // Position of the incoming pixel
  ////////////////////////////////////////////////////////////////////////////

  // frame_start forces this pixel to column 0 of row 0
  always_comb begin
    col_eff   = col;
    state_eff = state;
    if (frame_start) begin
      col_eff   = '0;
      state_eff = FILL_ROW0;
    end
  end

  assign rd_addr  = col_eff[ADDR_BITS-1:0];
  assign tap_prev = line_prev[rd_addr];
  assign tap_old  = line_old[rd_addr];

  // Column counter and row fill tracking
  always_ff @(posedge clk) begin
    if (reset) begin
      col   <= '0;
      state <= FILL_ROW0;
    end else if (pixel_valid) begin
      if (col_eff == LAST_COL) begin
        col <= '0;
        case (state_eff)
          FILL_ROW0: state <= FILL_ROW1;
          default:   state <= STREAM;
        endcase
      end else begin
        col   <= col_eff + col_t'(1);
        state <= state_eff;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Line buffers and window shift
  ////////////////////////////////////////////////////////////////////////////

  // Same column moves one row up in both buffers
  always_ff @(posedge clk) begin
    if (pixel_valid) begin
      line_prev[rd_addr] <= pixel_data;
      line_old[rd_addr]  <= tap_prev;
    end
  end

  // Window columns slide left, newest column enters at index 2
  always_ff @(posedge clk) begin
    if (pixel_valid) begin
      for (int i = 0; i < 2; i++) begin
        win.row_top[i] <= win.row_top[i+1];
        win.row_mid[i] <= win.row_mid[i+1];
        win.row_bot[i] <= win.row_bot[i+1];
      end
      win.row_top[2] <= tap_old;
      win.row_mid[2] <= tap_prev;
      win.row_bot[2] <= pixel_data;
    end
  end

  // Only windows lying fully inside the image
  always_ff @(posedge clk) begin
    if (reset) begin
      win.win_valid <= 1'b0;
    end else begin
      win.win_valid <= pixel_valid && (state_eff == STREAM) && (col_eff >= FIRST_WIN);
    end
  end

  // Counter wraps at the row end and never indexes past the buffers
  col_in_range: assert property (
    @(posedge clk) disable iff (reset) col < col_t'(`CONV_IMAGE_WIDTH)
  );

endmodule

/* conv_window_if.sv */
`timescale 1ns/1ps

// One 3x3 window, handed from decode to execute
interface conv_window_if;

  import conv_data_pkg::*;

  // Single-cycle strobe, no back-pressure
  logic   win_valid;

  // Index 0 is the left (oldest) column
  pixel_t row_top [3];
  pixel_t row_mid [3];
  pixel_t row_bot [3];

  modport producer (
    output win_valid,
    output row_top,
    output row_mid,
    output row_bot
  );

  modport consumer (
    input  win_valid,
    input  row_top,
    input  row_mid,
    input  row_bot
  );

endinterface

/* conv_geom_pkg.sv */
`include "conv_settings.svh"

package conv_geom_pkg;

  // Column counter, wide enough to hold the image width itself
  typedef logic [$clog2(`CONV_IMAGE_WIDTH + 1)-1:0] col_t;

  // Weight index, row * 3 + column
  typedef logic [3:0] tap_t;

  localparam int NUM_TAPS = 9;

  // How many complete rows sit in the line buffers
  typedef enum logic [1:0] {
    FILL_ROW0,
    FILL_ROW1,
    STREAM
  } fill_state_t;

endpackage

/* conv_data_pkg.sv */
`include "conv_settings.svh"

package conv_data_pkg;

  // Raw pixel and final result
  typedef logic signed [`CONV_PIXEL_WIDTH-1:0] pixel_t;

  // Fixed-point kernel coefficient
  typedef logic signed [`CONV_PIXEL_WIDTH-1:0] weight_t;

  // Full-precision pixel times weight
  typedef logic signed [2*`CONV_PIXEL_WIDTH-1:0] product_t;

  // Nine products need ceil(log2(9)) = 4 guard bits
  localparam int ACC_GUARD_BITS = 4;

  typedef logic signed [2*`CONV_PIXEL_WIDTH+ACC_GUARD_BITS-1:0] acc_t;

endpackage

/* conv_settings.svh */
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Image geometry
////////////////////////////////////////////////////////////////////////////

// Pixels per image row
`define CONV_IMAGE_WIDTH 8

////////////////////////////////////////////////////////////////////////////
// Arithmetic format
////////////////////////////////////////////////////////////////////////////

// Bits per pixel, also used for each weight
`define CONV_PIXEL_WIDTH 16

// Weights are signed fixed point with this many fraction bits
`define CONV_FRAC_BITS 4

`endif
